// File: hw/pdm2pcm_pkg.sv
// PDM to PCM peripheral sizes, register map and bit positions
`default_nettype none

package pdm2pcm_pkg;

  // Datapath and buffer sizes
  localparam int unsigned PCM_W      = 18;
  localparam int unsigned CIC_ORDER  = 4;
  localparam int unsigned FIFO_DEPTH = 8;
  localparam int unsigned FIFO_CNT_W = 4;
  localparam int unsigned FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Register field widths
  localparam int unsigned CLKDIV_W   = 16;
  localparam int unsigned DECIM_W    = 4;
  localparam int unsigned APB_ADDR_W = 12;

  // Register offsets
  localparam logic [APB_ADDR_W-1:0] ADDR_CONTROL = 12'h000;
  localparam logic [APB_ADDR_W-1:0] ADDR_STATUS  = 12'h004;
  localparam logic [APB_ADDR_W-1:0] ADDR_CLKDIV  = 12'h008;
  localparam logic [APB_ADDR_W-1:0] ADDR_DECIM   = 12'h00C;
  localparam logic [APB_ADDR_W-1:0] ADDR_REACH   = 12'h010;
  localparam logic [APB_ADDR_W-1:0] ADDR_RXDATA  = 12'h020;

  // CONTROL bits
  localparam int unsigned CTRL_EN_BIT    = 0;
  localparam int unsigned CTRL_CLEAR_BIT = 1;

  // STATUS bits
  localparam int unsigned STAT_EMPTY_BIT = 0;
  localparam int unsigned STAT_FULL_BIT  = 1;
  localparam int unsigned STAT_REACH_BIT = 2;

endpackage : pdm2pcm_pkg

`default_nettype wire

// File: hw/pdm2pcm_if.sv
// Configuration and FIFO read interfaces between the PDM to PCM blocks
`default_nettype none

interface pdm_cfg_if;

  logic                             enable;
  logic                             clear;
  logic [pdm2pcm_pkg::CLKDIV_W-1:0] clkdiv;
  logic [pdm2pcm_pkg::DECIM_W-1:0]  decim;

  modport regs (
    output enable,
    output clear,
    output clkdiv,
    output decim
  );

  modport core (
    input enable,
    input clear,
    input clkdiv,
    input decim
  );

  // The FIFO only needs the flush request
  modport fifo (
    input clear
  );

endinterface : pdm_cfg_if

interface pcm_rd_if;

  logic [pdm2pcm_pkg::PCM_W-1:0]      rdata;
  logic                               pop;
  logic                               empty;
  logic                               full;
  logic [pdm2pcm_pkg::FIFO_CNT_W-1:0] usage;

  modport regs (
    input  rdata,
    output pop,
    input  empty,
    input  full,
    input  usage
  );

  modport fifo (
    output rdata,
    input  pop,
    output empty,
    output full,
    output usage
  );

endinterface : pcm_rd_if

`default_nettype wire

// File: hw/pdm_core.sv
// PDM core with microphone clock divider, bit sampler and fourth-order CIC decimator
`default_nettype none

module pdm_core (
  input  logic                          clk_i,
  input  logic                          reset_i,
  pdm_cfg_if.core                       cfg_i,
  input  logic                          pdm_i,
  output logic                          pdm_clk_o,
  output logic [pdm2pcm_pkg::PCM_W-1:0] pcm_o,
  output logic                          pcm_valid_o
);

  logic [pdm2pcm_pkg::CLKDIV_W-1:0] div_cnt;
  logic                             pdm_clk_q;
  logic                             run;
  logic                             sample_stb;
  logic [pdm2pcm_pkg::DECIM_W-1:0]  samp_cnt;
  logic                             decim_pt;
  logic [pdm2pcm_pkg::PCM_W-1:0]    pdm_val;
  logic [pdm2pcm_pkg::PCM_W-1:0]    integ    [pdm2pcm_pkg::CIC_ORDER];
  logic [pdm2pcm_pkg::PCM_W-1:0]    comb_dly [pdm2pcm_pkg::CIC_ORDER];
  logic [pdm2pcm_pkg::PCM_W-1:0]    comb_in  [pdm2pcm_pkg::CIC_ORDER];
  logic [pdm2pcm_pkg::PCM_W-1:0]    comb_out [pdm2pcm_pkg::CIC_ORDER];
  logic [pdm2pcm_pkg::PCM_W-1:0]    pcm_q;
  logic                             pcm_valid_q;

  // Clear and disable both hold the whole datapath in its idle state
  assign run = cfg_i.enable && !cfg_i.clear;

  // Strobe on the cycle where the PDM clock goes high
  assign sample_stb = run && !pdm_clk_q && (div_cnt >= cfg_i.clkdiv);
  assign decim_pt   = sample_stb && (samp_cnt >= cfg_i.decim);

  // Bit 1 maps to +1, bit 0 maps to -1
  assign pdm_val = {{(pdm2pcm_pkg::PCM_W-1){~pdm_i}}, 1'b1};

  assign pdm_clk_o   = pdm_clk_q;
  assign pcm_o       = pcm_q;
  assign pcm_valid_o = pcm_valid_q;

  // Half period of the PDM clock is clkdiv+1 cycles
  always_ff @(posedge clk_i) begin
    if (reset_i || !run) begin
      div_cnt   <= '0;
      pdm_clk_q <= 1'b0;
    end else if (div_cnt >= cfg_i.clkdiv) begin
      div_cnt   <= '0;
      pdm_clk_q <= ~pdm_clk_q;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Integrator cascade, wraps modulo 2^PCM_W
  always_ff @(posedge clk_i) begin
    if (reset_i || !run) begin
      for (int k = 0; k < pdm2pcm_pkg::CIC_ORDER; k++) begin
        integ[k] <= '0;
      end
    end else if (sample_stb) begin
      integ[0] <= integ[0] + pdm_val;
      for (int k = 1; k < pdm2pcm_pkg::CIC_ORDER; k++) begin
        integ[k] <= integ[k] + integ[k-1];
      end
    end
  end

  // Comb chain at the decimated rate, differential delay of one
  always_comb begin
    comb_in[0]  = integ[pdm2pcm_pkg::CIC_ORDER-1];
    comb_out[0] = comb_in[0] - comb_dly[0];
    for (int k = 1; k < pdm2pcm_pkg::CIC_ORDER; k++) begin
      comb_in[k]  = comb_out[k-1];
      comb_out[k] = comb_in[k] - comb_dly[k];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || !run) begin
      samp_cnt    <= '0;
      pcm_valid_q <= 1'b0;
      for (int k = 0; k < pdm2pcm_pkg::CIC_ORDER; k++) begin
        comb_dly[k] <= '0;
      end
    end else begin
      pcm_valid_q <= decim_pt;
      if (decim_pt) begin
        samp_cnt <= '0;
        for (int k = 0; k < pdm2pcm_pkg::CIC_ORDER; k++) begin
          comb_dly[k] <= comb_in[k];
        end
      end else if (sample_stb) begin
        samp_cnt <= samp_cnt + 1'b1;
      end
    end
  end

  // Output word, qualified by pcm_valid_o
  always_ff @(posedge clk_i) begin
    if (decim_pt) begin
      pcm_q <= comb_out[pdm2pcm_pkg::CIC_ORDER-1];
    end
  end

endmodule : pdm_core

`default_nettype wire

// File: hw/pcm_fifo.sv
// PCM sample FIFO with flush, drop on full and usage count
`default_nettype none

module pcm_fifo (
  input  logic                          clk_i,
  input  logic                          reset_i,
  pdm_cfg_if.fifo                       cfg_i,
  input  logic [pdm2pcm_pkg::PCM_W-1:0] pcm_i,
  input  logic                          pcm_valid_i,
  pcm_rd_if.fifo                        rd_o
);

  logic [pdm2pcm_pkg::PCM_W-1:0]      mem [pdm2pcm_pkg::FIFO_DEPTH];
  logic [pdm2pcm_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [pdm2pcm_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [pdm2pcm_pkg::FIFO_CNT_W-1:0] count;
  logic                               push;
  logic                               pop;

  assign rd_o.empty = (count == '0);
  assign rd_o.full  = (count == pdm2pcm_pkg::FIFO_CNT_W'(pdm2pcm_pkg::FIFO_DEPTH));
  assign rd_o.usage = count;
  assign rd_o.rdata = mem[rd_ptr];

  // Samples arriving while full are lost
  assign push = pcm_valid_i && !rd_o.full;
  assign pop  = rd_o.pop && !rd_o.empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr] <= pcm_i;
    end
  end

  // Pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk_i) begin
    if (reset_i || cfg_i.clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule : pcm_fifo

`default_nettype wire

// File: hw/pdm2pcm_regs.sv
// APB register block with control, status, divider, decimation, threshold and RX window
`default_nettype none

module pdm2pcm_regs (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [pdm2pcm_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]                        pwdata_i,
  output logic [31:0]                        prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  pdm_cfg_if.regs                            cfg_o,
  pcm_rd_if.regs                             rd_o
);

  logic                               access;
  logic                               wr_en;
  logic                               rd_en;
  logic                               addr_hit;
  logic                               ctrl_en_q;
  logic                               clear_q;
  logic [pdm2pcm_pkg::CLKDIV_W-1:0]   clkdiv_q;
  logic [pdm2pcm_pkg::DECIM_W-1:0]    decim_q;
  logic [pdm2pcm_pkg::FIFO_CNT_W-1:0] reach_q;
  logic                               reach_flag;
  logic [31:0]                        rx_word;

  // No wait states, every access completes in one access phase
  assign access    = psel_i && penable_i;
  assign wr_en     = access && pwrite_i;
  assign rd_en     = access && !pwrite_i;
  assign pready_o  = access;
  assign pslverr_o = access && !addr_hit;

  assign cfg_o.enable = ctrl_en_q;
  assign cfg_o.clear  = clear_q;
  assign cfg_o.clkdiv = clkdiv_q;
  assign cfg_o.decim  = decim_q;

  assign reach_flag = (rd_o.usage > reach_q);

  // Head word sign-extended, zero when nothing is buffered
  assign rx_word = rd_o.empty ? 32'd0 :
                   {{(32-pdm2pcm_pkg::PCM_W){rd_o.rdata[pdm2pcm_pkg::PCM_W-1]}}, rd_o.rdata};

  // Reading the window consumes the head at the end of the access
  assign rd_o.pop = rd_en && (paddr_i == pdm2pcm_pkg::ADDR_RXDATA) && !rd_o.empty;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctrl_en_q <= 1'b0;
      clear_q   <= 1'b0;
      clkdiv_q  <= '0;
      decim_q   <= '0;
      reach_q   <= '0;
    end else begin
      // Self-clearing flush pulse
      clear_q <= wr_en && (paddr_i == pdm2pcm_pkg::ADDR_CONTROL) &&
                 pwdata_i[pdm2pcm_pkg::CTRL_CLEAR_BIT];
      if (wr_en) begin
        case (paddr_i)
          pdm2pcm_pkg::ADDR_CONTROL: ctrl_en_q <= pwdata_i[pdm2pcm_pkg::CTRL_EN_BIT];
          pdm2pcm_pkg::ADDR_CLKDIV:  clkdiv_q  <= pwdata_i[pdm2pcm_pkg::CLKDIV_W-1:0];
          pdm2pcm_pkg::ADDR_DECIM:   decim_q   <= pwdata_i[pdm2pcm_pkg::DECIM_W-1:0];
          pdm2pcm_pkg::ADDR_REACH:   reach_q   <= pwdata_i[pdm2pcm_pkg::FIFO_CNT_W-1:0];
          default: begin
          end
        endcase
      end
    end
  end

  // Read mux and address decode
  always_comb begin
    prdata_o = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      pdm2pcm_pkg::ADDR_CONTROL: prdata_o[pdm2pcm_pkg::CTRL_EN_BIT] = ctrl_en_q;
      pdm2pcm_pkg::ADDR_STATUS: begin
        prdata_o[pdm2pcm_pkg::STAT_EMPTY_BIT] = rd_o.empty;
        prdata_o[pdm2pcm_pkg::STAT_FULL_BIT]  = rd_o.full;
        prdata_o[pdm2pcm_pkg::STAT_REACH_BIT] = reach_flag;
      end
      pdm2pcm_pkg::ADDR_CLKDIV: prdata_o[pdm2pcm_pkg::CLKDIV_W-1:0] = clkdiv_q;
      pdm2pcm_pkg::ADDR_DECIM:  prdata_o[pdm2pcm_pkg::DECIM_W-1:0]  = decim_q;
      pdm2pcm_pkg::ADDR_REACH:  prdata_o[pdm2pcm_pkg::FIFO_CNT_W-1:0] = reach_q;
      pdm2pcm_pkg::ADDR_RXDATA: prdata_o = rx_word;
      default:                  addr_hit = 1'b0;
    endcase
  end

endmodule : pdm2pcm_regs

`default_nettype wire

// File: hw/pdm2pcm.sv
// PDM to PCM acquisition peripheral top with APB slave and PDM microphone ports
`default_nettype none

module pdm2pcm (
  input  logic                               clk_i,
  input  logic                               reset_i,

  // APB slave
  input  logic                               psel_i,
  input  logic                               penable_i,
  input  logic                               pwrite_i,
  input  logic [pdm2pcm_pkg::APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]                        pwdata_i,
  output logic [31:0]                        prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,

  // PDM microphone
  input  logic                               pdm_i,
  output logic                               pdm_clk_o
);

  logic [pdm2pcm_pkg::PCM_W-1:0] pcm;
  logic                          pcm_valid;

  pdm_cfg_if cfg_if ();
  pcm_rd_if  rd_if ();

  pdm2pcm_regs regs_i (
    .clk_i,
    .reset_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .cfg_o     (cfg_if.regs),
    .rd_o      (rd_if.regs)
  );

  pdm_core core_i (
    .clk_i,
    .reset_i,
    .cfg_i       (cfg_if.core),
    .pdm_i,
    .pdm_clk_o,
    .pcm_o       (pcm),
    .pcm_valid_o (pcm_valid)
  );

  pcm_fifo fifo_i (
    .clk_i,
    .reset_i,
    .cfg_i       (cfg_if.fifo),
    .pcm_i       (pcm),
    .pcm_valid_i (pcm_valid),
    .rd_o        (rd_if.fifo)
  );

endmodule : pdm2pcm

`default_nettype wire

// File: tests/tb_clock.sv
// Clock and reset generator for the PDM to PCM testbench
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic reset_o
);

  // Period of 8 time units
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset spans two rising edges and drops on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule : tb_clock

`default_nettype wire

// File: tests/tb_pdm2pcm.sv
// Directed testbench for the PDM to PCM peripheral over APB
`default_nettype none

module tb_pdm2pcm;

  localparam int unsigned APB_LIMIT  = 16;
  localparam int unsigned POLL_LIMIT = 400;
  localparam int unsigned RISE_LIMIT = 100;

  localparam logic [31:0] CTRL_EN    = 32'd1 << pdm2pcm_pkg::CTRL_EN_BIT;
  localparam logic [31:0] CTRL_CLEAR = 32'd1 << pdm2pcm_pkg::CTRL_CLEAR_BIT;
  localparam logic [31:0] STAT_EMPTY = 32'd1 << pdm2pcm_pkg::STAT_EMPTY_BIT;
  localparam logic [31:0] STAT_FULL  = 32'd1 << pdm2pcm_pkg::STAT_FULL_BIT;
  localparam logic [31:0] STAT_REACH = 32'd1 << pdm2pcm_pkg::STAT_REACH_BIT;

  logic                               clk;
  logic                               reset;
  logic                               psel;
  logic                               penable;
  logic                               pwrite;
  logic [pdm2pcm_pkg::APB_ADDR_W-1:0] paddr;
  logic [31:0]                        pwdata;
  logic [31:0]                        prdata;
  logic                               pready;
  logic                               pslverr;
  logic                               pdm;
  logic                               pdm_clk;
  logic                               pdm_random;
  logic                               pdm_level;
  logic                               pdm_clk_last;
  logic [63:0]                        rand_bits;
  logic [5:0]                         rand_idx;
  int                                 errors;
  int                                 checks;

  tb_clock clock_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  pdm2pcm pdm2pcm_i (
    .clk_i     (clk),
    .reset_i   (reset),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .pdm_i     (pdm),
    .pdm_clk_o (pdm_clk)
  );

  // Microphone model that puts out a new random bit after each rising PDM clock edge
  always @(negedge clk) begin
    if (!pdm_random) begin
      pdm = pdm_level;
    end else if (pdm_clk && !pdm_clk_last) begin
      pdm      = rand_bits[rand_idx];
      rand_idx = rand_idx + 1'b1;
    end
    pdm_clk_last = pdm_clk;
  end

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Done: errors found");
    $finish;
  endtask

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // One APB transfer with a setup phase and an access phase that lasts until pready
  task automatic apb_xfer(input logic write, input logic [pdm2pcm_pkg::APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int unsigned waited;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    waited  = 0;
    @(posedge clk);
    while (!pready) begin
      waited++;
      if (waited > APB_LIMIT) begin
        stop_on_timeout("APB pready");
      end
      @(posedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [pdm2pcm_pkg::APB_ADDR_W-1:0] addr,
                           input logic [31:0] data);
    logic [31:0] unused_rdata;
    logic        unused_err;
    apb_xfer(1'b1, addr, data, unused_rdata, unused_err);
  endtask

  task automatic apb_read(input logic [pdm2pcm_pkg::APB_ADDR_W-1:0] addr,
                          output logic [31:0] data, output logic err);
    apb_xfer(1'b0, addr, 32'd0, data, err);
  endtask

  // Poll STATUS until the masked bits match
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                             input string what);
    logic [31:0] st;
    logic        err;
    int unsigned polls;
    polls = 0;
    apb_read(pdm2pcm_pkg::ADDR_STATUS, st, err);
    while ((st & mask) != value) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        stop_on_timeout(what);
      end
      apb_read(pdm2pcm_pkg::ADDR_STATUS, st, err);
    end
  endtask

  task automatic pop_word(output logic [31:0] word);
    logic err;
    wait_status(STAT_EMPTY, 32'd0, "a PCM word");
    apb_read(pdm2pcm_pkg::ADDR_RXDATA, word, err);
  endtask

  task automatic skip_words(input int n);
    logic [31:0] unused;
    repeat (n) pop_word(unused);
  endtask

  // Cycles counted from the call to the next rising PDM clock edge
  task automatic time_pdm_rise(output int cycles);
    logic prev;
    logic rose;
    prev   = pdm_clk;
    rose   = 1'b0;
    cycles = 0;
    while (!rose) begin
      @(posedge clk);
      cycles++;
      if (cycles > RISE_LIMIT) begin
        stop_on_timeout("a rising PDM clock edge");
      end
      rose = pdm_clk && !prev;
      prev = pdm_clk;
    end
  endtask

  task automatic count_pdm_high(input int cycles, output int highs);
    highs = 0;
    repeat (cycles) begin
      @(posedge clk);
      if (pdm_clk !== 1'b0) begin
        highs++;
      end
    end
  endtask

  // Steady CIC output for a constant input is plus or minus R to the fourth
  function automatic logic [31:0] cic_gain(input int r, input logic level);
    int g;
    g = r * r * r * r;
    return level ? 32'(g) : 32'(-g);
  endfunction

  // Disable, flush, configure and enable with a constant input
  task automatic start_capture(input logic [31:0] clkdiv, input logic [31:0] decim,
                               input logic level);
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, CTRL_CLEAR);
    apb_write(pdm2pcm_pkg::ADDR_CLKDIV, clkdiv);
    apb_write(pdm2pcm_pkg::ADDR_DECIM, decim);
    pdm_random = 1'b0;
    pdm_level  = level;
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, CTRL_EN);
  endtask

  task automatic regs_after_reset();
    logic [31:0] d;
    logic        e;
    int          highs;
    check_eq("pready idle after reset", pready, 1'b0);
    check_eq("pslverr idle after reset", pslverr, 1'b0);
    apb_read(pdm2pcm_pkg::ADDR_STATUS, d, e);
    check_eq("STATUS after reset", d, STAT_EMPTY);
    count_pdm_high(20, highs);
    check_eq("PDM clock idle after reset", highs, 0);
    apb_write(pdm2pcm_pkg::ADDR_CLKDIV, 32'h1234_abcd);
    apb_read(pdm2pcm_pkg::ADDR_CLKDIV, d, e);
    check_eq("CLKDIV readback", d, 32'h0000_abcd);
    apb_write(pdm2pcm_pkg::ADDR_DECIM, 32'h0000_002f);
    apb_read(pdm2pcm_pkg::ADDR_DECIM, d, e);
    check_eq("DECIM readback", d, 32'h0000_000f);
    apb_write(pdm2pcm_pkg::ADDR_REACH, 32'h0000_005a);
    apb_read(pdm2pcm_pkg::ADDR_REACH, d, e);
    check_eq("REACH readback", d, 32'h0000_000a);
    check_eq("no pslverr on mapped read", e, 1'b0);
    apb_read(12'h014, d, e);
    check_eq("pslverr on unmapped read", e, 1'b1);
  endtask

  task automatic pdm_clock_period();
    int c;
    apb_write(pdm2pcm_pkg::ADDR_CLKDIV, 32'd3);
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, CTRL_EN);
    time_pdm_rise(c);
    time_pdm_rise(c);
    check_eq("PDM clock period with clkdiv 3", c, 8);
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, 32'd0);
  endtask

  task automatic decimation_gain(input int r, input logic level);
    logic [31:0] d;
    start_capture(32'd0, r - 1, level);
    skip_words(4);
    repeat (3) begin
      pop_word(d);
      check_eq($sformatf("RXDATA at R=%0d, input %0d", r, level), d, cic_gain(r, level));
    end
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, 32'd0);
  endtask

  task automatic fifo_flags();
    logic [31:0] d;
    logic        e;
    apb_write(pdm2pcm_pkg::ADDR_REACH, 32'd2);
    start_capture(32'd0, 32'd15, 1'b1);
    skip_words(4);
    wait_status(STAT_REACH, STAT_REACH, "the reach flag");
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, 32'd0);
    apb_read(pdm2pcm_pkg::ADDR_STATUS, d, e);
    check_eq("STATUS with 3 words", d, STAT_REACH);
    pop_word(d);
    check_eq("word before reach drop", d, cic_gain(16, 1'b1));
    apb_read(pdm2pcm_pkg::ADDR_STATUS, d, e);
    check_eq("STATUS with 2 words", d, 32'd0);
    // Exactly two words remain when the flag rose at three
    repeat (2) begin
      apb_read(pdm2pcm_pkg::ADDR_RXDATA, d, e);
      check_eq("word left after reach drop", d, cic_gain(16, 1'b1));
    end
    apb_read(pdm2pcm_pkg::ADDR_STATUS, d, e);
    check_eq("STATUS after three words", d, STAT_EMPTY);

    // Fill with steady words, then let a few more arrive and drop
    start_capture(32'd0, 32'd15, 1'b1);
    skip_words(4);
    wait_status(STAT_FULL, STAT_FULL, "the full flag");
    repeat (100) @(negedge clk);
    apb_read(pdm2pcm_pkg::ADDR_STATUS, d, e);
    check_eq("STATUS when full", d, STAT_FULL | STAT_REACH);
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, 32'd0);
    repeat (8) begin
      apb_read(pdm2pcm_pkg::ADDR_RXDATA, d, e);
      check_eq("word from full FIFO", d, cic_gain(16, 1'b1));
    end
    apb_read(pdm2pcm_pkg::ADDR_RXDATA, d, e);
    check_eq("RXDATA when empty", d, 32'd0);
    apb_read(pdm2pcm_pkg::ADDR_STATUS, d, e);
    check_eq("STATUS after draining", d, STAT_EMPTY);
  endtask

  task automatic clear_and_disable();
    logic [31:0] d;
    logic        e;
    int          highs;
    start_capture(32'd0, 32'd7, 1'b1);
    wait_status(STAT_EMPTY, 32'd0, "a word before clear");
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, CTRL_EN | CTRL_CLEAR);
    apb_read(pdm2pcm_pkg::ADDR_STATUS, d, e);
    check_eq("STATUS after clear", d, STAT_EMPTY);
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, 32'd0);
    // Divider resets on the edge after enable drops
    @(posedge clk);
    count_pdm_high(20, highs);
    check_eq("PDM clock stopped when disabled", highs, 0);

    // Random input followed by constant ones must settle to R to the fourth
    pdm_random = 1'b1;
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, CTRL_EN);
    skip_words(6);
    pdm_level  = 1'b1;
    pdm_random = 1'b0;
    skip_words(4);
    pop_word(d);
    check_eq("word after random input", d, cic_gain(8, 1'b1));
    apb_write(pdm2pcm_pkg::ADDR_CONTROL, 32'd0);
  endtask

  initial begin
    int waited;
    rand_bits[63:32] = $urandom(68044);
    rand_bits[31:0]  = $urandom();
    rand_idx     = '0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    pdm          = 1'b0;
    pdm_random   = 1'b0;
    pdm_level    = 1'b0;
    pdm_clk_last = 1'b0;
    errors       = 0;
    checks       = 0;
    waited       = 0;
    @(posedge clk);
    while (reset !== 1'b0) begin
      waited++;
      if (waited > 20) begin
        stop_on_timeout("reset release");
      end
      @(posedge clk);
    end

    regs_after_reset();
    pdm_clock_period();
    decimation_gain(8, 1'b1);
    decimation_gain(8, 1'b0);
    decimation_gain(16, 1'b1);
    decimation_gain(16, 1'b0);
    fifo_flags();
    clear_and_disable();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : tb_pdm2pcm

`default_nettype wire

// File: compile.f
hw/pdm2pcm_pkg.sv
hw/pdm2pcm_if.sv
hw/pdm_core.sv
hw/pcm_fifo.sv
hw/pdm2pcm_regs.sv
hw/pdm2pcm.sv
tests/tb_clock.sv
tests/tb_pdm2pcm.sv

// File: Bender.yml
package:
  name: pdm2pcm

sources:
  - hw/pdm2pcm_pkg.sv
  - hw/pdm2pcm_if.sv
  - hw/pdm_core.sv
  - hw/pcm_fifo.sv
  - hw/pdm2pcm_regs.sv
  - hw/pdm2pcm.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_pdm2pcm.sv
